/* sim.f */
+incdir+verilog
verilog/cart_pkg.sv
verilog/cart_bus_if.sv
verilog/cart_ascii16.sv
verilog/cart_ascii8.sv
verilog/cart_slot.sv
verilog/cart_mem_req.sv
verilog/cart_top.sv
verif/cart_checker.sv
verif/tb_cart.sv

/* verif/cart_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_checker import cart_pkg::*; (
    input  wire            clk,
    input  wire            reset,
    input  wire            cpu_wait,
    input  wire            mem_req_valid,
    input  cart_mem_addr_t mem_req_addr,
    input  wire            mem_req_rnw,
    input  wire            mem_req_sram,
    input  wire     [7:0]  mem_req_wdata,
    input  wire            row_done,
    input  wire            exp_req,
    input  cart_mem_addr_t exp_addr,
    input  wire            exp_rnw,
    input  wire            exp_sram,
    input  wire     [7:0]  exp_wdata,
    input  wire            exp_wait,
    output int             error_count,
    output int             req_count
);

    logic seen;
    logic wait_seen;

    initial begin
        error_count = 0;
        req_count   = 0;
        seen        = 1'b0;
        wait_seen   = 1'b0;
    end

    always @(posedge clk) begin
        if (reset) begin
            seen      = 1'b0;
            wait_seen = 1'b0;
        end else begin
            if (mem_req_valid) begin
                req_count++;
                if (!exp_req) begin
                    $display("Memory request to %h appeared for an access that expects none",
                             mem_req_addr);
                    error_count++;
                end else if (seen) begin
                    $display("More than one memory request was issued for one access");
                    error_count++;
                end else begin
                    if (mem_req_addr != exp_addr) begin
                        // Show the bank or SRAM offset that the request decoded to
                        if (mem_req_sram) begin
                            $display("ERR mem_req_addr expected %h got %h (sram offset %h)",
                                     exp_addr, mem_req_addr, mem_req_addr.sram.offset);
                        end else begin
                            $display("ERR mem_req_addr expected %h got %h (rom bank %h)",
                                     exp_addr, mem_req_addr, mem_req_addr.rom.bank);
                        end
                        error_count++;
                    end
                    if (mem_req_rnw != exp_rnw) begin
                        $display("ERR mem_req_rnw expected %h got %h", exp_rnw, mem_req_rnw);
                        error_count++;
                    end
                    if (mem_req_sram != exp_sram) begin
                        $display("ERR mem_req_sram expected %h got %h", exp_sram, mem_req_sram);
                        error_count++;
                    end
                    // Write data only matters on writes
                    if (!exp_rnw && mem_req_wdata != exp_wdata) begin
                        $display("ERR mem_req_wdata expected %h got %h",
                                 exp_wdata, mem_req_wdata);
                        error_count++;
                    end
                end
                seen = 1'b1;
            end
            if (mem_req_valid && cpu_wait) begin
                $display("CPU wait was still high while the request was issued");
                error_count++;
            end
            if (cpu_wait) begin
                wait_seen = 1'b1;
            end
            if (row_done) begin
                if (exp_req && !seen) begin
                    $display("Expected memory request to %h was never issued", exp_addr);
                    error_count++;
                end
                if (exp_wait != wait_seen) begin
                    $display("CPU wait was %s during the access, but %s was expected",
                             wait_seen ? "raised" : "not raised",
                             exp_wait ? "a wait" : "no wait");
                    error_count++;
                end
                seen      = 1'b0;
                wait_seen = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* verif/tb_cart.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cart_settings.svh"

module tb_cart import cart_pkg::*; ();

    typedef struct packed {
        mapper_typ_t  mapper;
        logic         id;
        logic [24:0]  rom_size;
        logic [15:0]  sram_size;
        logic         rd;
        logic         wr;
        logic [15:0]  addr;
        logic [7:0]   data;
        logic         hold;
        logic         req;
        logic [26:0]  exp_addr;
        logic         sram;
        logic         wait_exp;
    } row_t;

    logic                    clk;
    logic                    reset;
    logic                    cpu_mreq;
    logic                    cpu_rd;
    logic                    cpu_wr;
    logic [7:0]              cpu_data;
    logic [15:0]             cpu_addr;
    logic [24:0]             rom_size;
    logic [15:0]             sram_size;
    mapper_typ_t             mapper;
    logic                    mapper_id;
    logic                    mem_credit_return;
    wire                     cpu_wait;
    wire                     mem_req_valid;
    wire [`CART_ADDR_W-1:0]  mem_req_addr;
    wire                     mem_req_rnw;
    wire                     mem_req_sram;
    wire [7:0]               mem_req_wdata;

    logic        row_done;
    logic        exp_req;
    logic [26:0] exp_addr;
    logic        exp_rnw;
    logic        exp_sram;
    logic [7:0]  exp_wdata;
    logic        exp_wait;
    logic        hold_credits;
    int          error_count;
    int          req_count;
    int          cycle;
    int          timeout_limit;
    row_t        rows[$];
    int          due_q[$];

    cart_top i_dut (
        .clk               (clk),
        .reset             (reset),
        .cpu_mreq          (cpu_mreq),
        .cpu_rd            (cpu_rd),
        .cpu_wr            (cpu_wr),
        .cpu_data          (cpu_data),
        .cpu_addr          (cpu_addr),
        .rom_size          (rom_size),
        .sram_size         (sram_size),
        .mapper            (mapper),
        .mapper_id         (mapper_id),
        .mem_credit_return (mem_credit_return),
        .cpu_wait          (cpu_wait),
        .mem_req_valid     (mem_req_valid),
        .mem_req_addr      (mem_req_addr),
        .mem_req_rnw       (mem_req_rnw),
        .mem_req_sram      (mem_req_sram),
        .mem_req_wdata     (mem_req_wdata)
    );

    cart_checker i_checker (
        .clk           (clk),
        .reset         (reset),
        .cpu_wait      (cpu_wait),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_rnw   (mem_req_rnw),
        .mem_req_sram  (mem_req_sram),
        .mem_req_wdata (mem_req_wdata),
        .row_done      (row_done),
        .exp_req       (exp_req),
        .exp_addr      (exp_addr),
        .exp_rnw       (exp_rnw),
        .exp_sram      (exp_sram),
        .exp_wdata     (exp_wdata),
        .exp_wait      (exp_wait),
        .error_count   (error_count),
        .req_count     (req_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // 16 KB bank number and CPU address to a byte address in ROM
    function automatic logic [26:0] bank16_addr(input logic [7:0] bank, input logic [15:0] a);
        return 27'(bank) * 27'h4000 + 27'(a & 16'h3FFF);
    endfunction

    // 8 KB bank number and CPU address to a byte address in ROM
    function automatic logic [26:0] bank8_addr(input logic [7:0] bank, input logic [15:0] a);
        return 27'(bank) * 27'h2000 + 27'(a & 16'h1FFF);
    endfunction

    task automatic add_row(input mapper_typ_t m, input logic id, input logic [24:0] rs,
                           input logic [15:0] ss, input logic wr, input logic [15:0] a,
                           input logic [7:0] d, input logic hold, input logic req,
                           input logic [26:0] ea, input logic sram, input logic wait_exp);
        row_t r;
        r = '{m, id, rs, ss, ~wr, wr, a, d, hold, req, ea, sram, wait_exp};
        rows.push_back(r);
    endtask

    // Memory side: one credit back a few cycles after each request
    always @(posedge clk) begin
        if (reset) begin
            mem_credit_return <= 1'b0;
            due_q.delete();
        end else begin
            mem_credit_return <= 1'b0;
            if (mem_req_valid) begin
                due_q.push_back(cycle + 3);
            end
            if (!hold_credits && due_q.size() > 0 && due_q[0] <= cycle) begin
                mem_credit_return <= 1'b1;
                void'(due_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("sim failed");
            $finish;
        end
    end

    task automatic run_row(input row_t r);
        int waited;
        waited = 0;
        @(posedge clk);
        row_done     <= 1'b0;
        exp_req      <= r.req;
        exp_addr     <= r.exp_addr;
        exp_rnw      <= r.rd;
        exp_sram     <= r.sram;
        exp_wdata    <= r.data;
        exp_wait     <= r.wait_exp;
        hold_credits <= r.hold;
        mapper       <= r.mapper;
        mapper_id    <= r.id;
        rom_size     <= r.rom_size;
        sram_size    <= r.sram_size;
        cpu_mreq     <= 1'b1;
        cpu_rd       <= r.rd;
        cpu_wr       <= r.wr;
        cpu_addr     <= r.addr;
        cpu_data     <= r.data;
        @(posedge clk);
        cpu_mreq <= 1'b0;
        cpu_rd   <= 1'b0;
        cpu_wr   <= 1'b0;
        repeat (3) @(posedge clk);
        // Stalled access, let credits flow again after a while
        while (cpu_wait) begin
            @(posedge clk);
            waited++;
            if (waited == 3) begin
                hold_credits <= 1'b0;
            end
        end
        @(posedge clk);
        row_done <= 1'b1;
    endtask

    initial begin
        cycle             = 0;
        timeout_limit     = 100000;
        reset             = 1'b1;
        cpu_mreq          = 1'b0;
        cpu_rd            = 1'b0;
        cpu_wr            = 1'b0;
        cpu_data          = 8'h00;
        cpu_addr          = 16'h0000;
        rom_size          = 25'h0;
        sram_size         = 16'h0;
        mapper            = MAPPER_NONE;
        mapper_id         = 1'b0;
        mem_credit_return = 1'b0;
        row_done          = 1'b0;
        exp_req           = 1'b0;
        exp_addr          = '0;
        exp_rnw           = 1'b1;
        exp_sram          = 1'b0;
        exp_wdata         = 8'h00;
        exp_wait          = 1'b0;
        hold_credits      = 1'b0;

        // ASCII16 bank switching, 128 KB ROM
        add_row(MAPPER_ASCII16, 0, 25'h20000, 0, 1, 16'h6000, 8'h03, 0, 0, 0, 0, 0);
        add_row(MAPPER_ASCII16, 0, 25'h20000, 0, 1, 16'h7000, 8'h05, 0, 0, 0, 0, 0);
        add_row(MAPPER_ASCII16, 0, 25'h20000, 0, 0, 16'h4123, 8'h00, 0, 1,
                bank16_addr(8'h03, 16'h4123), 0, 0);
        add_row(MAPPER_ASCII16, 0, 25'h20000, 0, 0, 16'h8456, 8'h00, 0, 1,
                bank16_addr(8'h05, 16'h8456), 0, 0);
        add_row(MAPPER_ASCII16, 0, 25'h20000, 0, 1, 16'h8000, 8'h55, 0, 0, 0, 0, 0);
        add_row(MAPPER_ASCII16, 0, 25'h20000, 0, 1, 16'h7000, 8'h09, 0, 0, 0, 0, 0);
        add_row(MAPPER_ASCII16, 0, 25'h20000, 0, 0, 16'h8000, 8'h00, 0, 0, 0, 0, 0);
        // Second cartridge keeps its own banks
        add_row(MAPPER_ASCII16, 1, 25'h20000, 0, 0, 16'h4123, 8'h00, 0, 1,
                bank16_addr(8'h00, 16'h4123), 0, 0);
        add_row(MAPPER_ASCII16, 1, 25'h20000, 0, 1, 16'h6000, 8'h02, 0, 0, 0, 0, 0);
        add_row(MAPPER_ASCII16, 1, 25'h20000, 0, 0, 16'h4010, 8'h00, 0, 1,
                bank16_addr(8'h02, 16'h4010), 0, 0);
        add_row(MAPPER_ASCII16, 0, 25'h20000, 0, 0, 16'h4123, 8'h00, 0, 1,
                bank16_addr(8'h03, 16'h4123), 0, 0);
        // R-Type, 512 KB ROM
        add_row(MAPPER_RTYPE, 0, 25'h80000, 0, 1, 16'h7000, 8'h1A, 0, 0, 0, 0, 0);
        add_row(MAPPER_RTYPE, 0, 25'h80000, 0, 0, 16'h8001, 8'h00, 0, 1,
                bank16_addr(8'h1A & 8'h17, 16'h8001), 0, 0);
        add_row(MAPPER_RTYPE, 0, 25'h80000, 0, 1, 16'h7800, 8'hEB, 0, 0, 0, 0, 0);
        add_row(MAPPER_RTYPE, 0, 25'h80000, 0, 0, 16'hA002, 8'h00, 0, 1,
                bank16_addr(8'hEB & 8'h1F, 16'hA002), 0, 0);
        add_row(MAPPER_RTYPE, 0, 25'h80000, 0, 0, 16'h4100, 8'h00, 0, 1,
                bank16_addr(8'h0F, 16'h4100), 0, 0);
        // SRAM on cartridge 1, 8 KB then 2 KB then none
        add_row(MAPPER_ASCII16, 1, 25'h20000, 8, 1, 16'h7000, 8'h10, 0, 0, 0, 0, 0);
        add_row(MAPPER_ASCII16, 1, 25'h20000, 8, 0, 16'h9ABC, 8'h00, 0, 1, 27'h1ABC, 1, 0);
        add_row(MAPPER_ASCII16, 1, 25'h20000, 8, 1, 16'hB123, 8'h5A, 0, 1, 27'h1123, 1, 0);
        add_row(MAPPER_ASCII16, 1, 25'h20000, 2, 0, 16'h9ABC, 8'h00, 0, 1, 27'h02BC, 1, 0);
        add_row(MAPPER_ASCII16, 1, 25'h20000, 2, 1, 16'hBFFF, 8'hC3, 0, 1, 27'h07FF, 1, 0);
        add_row(MAPPER_ASCII16, 1, 25'h100000, 0, 1, 16'h7000, 8'h10, 0, 0, 0, 0, 0);
        add_row(MAPPER_ASCII16, 1, 25'h100000, 0, 0, 16'h8000, 8'h00, 0, 1,
                bank16_addr(8'h10, 16'h8000), 0, 0);
        // ASCII8 windows
        add_row(MAPPER_ASCII8, 0, 25'h20000, 0, 1, 16'h6000, 8'h01, 0, 0, 0, 0, 0);
        add_row(MAPPER_ASCII8, 0, 25'h20000, 0, 1, 16'h6800, 8'h02, 0, 0, 0, 0, 0);
        add_row(MAPPER_ASCII8, 0, 25'h20000, 0, 1, 16'h7000, 8'h03, 0, 0, 0, 0, 0);
        add_row(MAPPER_ASCII8, 0, 25'h20000, 0, 1, 16'h7800, 8'h0F, 0, 0, 0, 0, 0);
        add_row(MAPPER_ASCII8, 0, 25'h20000, 0, 0, 16'h4010, 8'h00, 0, 1,
                bank8_addr(8'h01, 16'h4010), 0, 0);
        add_row(MAPPER_ASCII8, 0, 25'h20000, 0, 0, 16'h6020, 8'h00, 0, 1,
                bank8_addr(8'h02, 16'h6020), 0, 0);
        add_row(MAPPER_ASCII8, 0, 25'h20000, 0, 0, 16'h8030, 8'h00, 0, 1,
                bank8_addr(8'h03, 16'h8030), 0, 0);
        add_row(MAPPER_ASCII8, 0, 25'h20000, 0, 0, 16'hA040, 8'h00, 0, 1,
                bank8_addr(8'h0F, 16'hA040), 0, 0);
        // Credits withheld, third access has to wait
        add_row(MAPPER_ASCII8, 0, 25'h20000, 0, 0, 16'h4000, 8'h00, 1, 1,
                bank8_addr(8'h01, 16'h4000), 0, 0);
        add_row(MAPPER_ASCII8, 0, 25'h20000, 0, 0, 16'h6000, 8'h00, 1, 1,
                bank8_addr(8'h02, 16'h6000), 0, 0);
        add_row(MAPPER_ASCII8, 0, 25'h20000, 0, 0, 16'h8000, 8'h00, 1, 1,
                bank8_addr(8'h03, 16'h8000), 0, 1);
        add_row(MAPPER_ASCII8, 0, 25'h20000, 0, 0, 16'hA000, 8'h00, 0, 1,
                bank8_addr(8'h0F, 16'hA000), 0, 0);

        timeout_limit = rows.size() * 20 + 20;

        repeat (5) @(posedge clk);
        reset <= 1'b0;

        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        @(posedge clk);
        row_done <= 1'b0;
        repeat (2) @(posedge clk);

        $display("Closing: %0d errors, %0d requests checked over %0d accesses",
                 error_count, req_count, rows.size());
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/cart_ascii16.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_ascii16 import cart_pkg::*; (
    input  wire            clk,
    input  wire            reset,
    cart_bus_if.mapper     bus,
    input  wire     [24:0] rom_size,
    input  wire     [15:0] sram_size,
    input  mapper_typ_t    mapper,
    input  wire            mapper_id,
    output cart_mem_addr_t mem_addr,
    output logic           mem_rnw,
    output logic           ram_cs,
    output logic           sram_cs
);

    logic        mapped;
    logic        mapper_en;
    logic        mode_rtype;
    logic        cs;
    logic        sram_exists;
    logic [7:0]  bank0 [2];
    logic [7:0]  bank1 [2];
    logic [1:0]  sram_enable [2];
    logic [7:0]  bank_base;
    logic        sram_en;
    logic [21:0] rom_addr;
    logic        rom_valid;

    // Window 4000-BFFF only
    assign mapped      = ^bus.addr[15:14];
    assign mapper_en   = (mapper == MAPPER_ASCII16) || (mapper == MAPPER_RTYPE);
    assign mode_rtype  = (mapper == MAPPER_RTYPE);
    assign cs          = mapped & mapper_en & bus.mreq;
    assign sram_exists = (sram_size != 16'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            bank0       <= '{8'h00, 8'h00};
            bank1       <= '{8'h00, 8'h00};
            sram_enable <= '{2'b00, 2'b00};
        end else if (cs && bus.wr) begin
            if (mode_rtype) begin
                // R-Type only switches the upper window
                if (bus.addr[15:12] == 4'b0111) begin
                    bank1[mapper_id] <= bus.data & (bus.data[4] ? 8'h17 : 8'h1F);
                end
            end else begin
                case (bus.addr[15:11])
                    5'b01100: begin
                        if (bus.data == 8'h10 && sram_exists) begin
                            sram_enable[mapper_id][0] <= 1'b1;
                        end else begin
                            sram_enable[mapper_id][0] <= 1'b0;
                            bank0[mapper_id]          <= bus.data;
                        end
                    end
                    5'b01110: begin
                        if (bus.data == 8'h10 && sram_exists) begin
                            sram_enable[mapper_id][1] <= 1'b1;
                        end else begin
                            sram_enable[mapper_id][1] <= 1'b0;
                            bank1[mapper_id]          <= bus.data;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // Lower window is pinned to bank 0Fh in R-Type mode
    assign bank_base = bus.addr[15] ? bank1[mapper_id] :
                       (mode_rtype ? 8'h0F : bank0[mapper_id]);
    assign sram_en   = ~mode_rtype & sram_enable[mapper_id][bus.addr[15]];
    assign rom_addr  = {bank_base, bus.addr[13:0]};
    assign rom_valid = ({3'b000, rom_addr} < rom_size);

    // SRAM is writable only in the upper window
    assign sram_cs = cs & sram_en & (bus.rd | (bus.wr & bus.addr[15]));
    assign ram_cs  = cs & ~sram_en & rom_valid & bus.rd;
    assign mem_rnw = ~(sram_cs & bus.wr);

    always_comb begin
        mem_addr = '1;
        if (cs) begin
            if (sram_en) begin
                mem_addr.sram.pad    = '0;
                mem_addr.sram.offset = (sram_size > 16'd2) ? bus.addr[12:0] :
                                       {2'b00, bus.addr[10:0]};
            end else begin
                mem_addr.rom.pad    = '0;
                mem_addr.rom.bank   = bank_base;
                mem_addr.rom.offset = bus.addr[13:0];
            end
        end
    end

    // A ROM select always points inside the cartridge image
    a_rom_in_range: assert property (@(posedge clk) disable iff (reset)
        ram_cs |-> (mem_addr < {2'b00, rom_size}));

endmodule

`default_nettype wire

/* verilog/cart_ascii8.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_ascii8 import cart_pkg::*; (
    input  wire            clk,
    input  wire            reset,
    cart_bus_if.mapper     bus,
    input  wire     [24:0] rom_size,
    input  wire     [15:0] sram_size,
    input  mapper_typ_t    mapper,
    input  wire            mapper_id,
    output cart_mem_addr_t mem_addr,
    output logic           mem_rnw,
    output logic           ram_cs,
    output logic           sram_cs
);

    logic        mapped;
    logic        cs;
    logic        sram_exists;
    logic [7:0]  bank [2][4];
    logic [3:0]  sram_enable [2];
    logic [1:0]  window;
    logic [7:0]  bank_sel;
    logic        sram_en;
    logic [20:0] rom_addr;
    logic        rom_valid;

    assign mapped      = ^bus.addr[15:14];
    assign cs          = mapped & (mapper == MAPPER_ASCII8) & bus.mreq;
    assign sram_exists = (sram_size != 16'd0);

    // Registers at 6000, 6800, 7000 and 7800
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2; i++) begin
                for (int w = 0; w < 4; w++) begin
                    bank[i][w] <= 8'h00;
                end
                sram_enable[i] <= 4'b0000;
            end
        end else if (cs && bus.wr && bus.addr[15:13] == 3'b011) begin
            if (bus.data >= 8'h20 && sram_exists) begin
                sram_enable[mapper_id][bus.addr[12:11]] <= 1'b1;
            end else begin
                sram_enable[mapper_id][bus.addr[12:11]] <= 1'b0;
                bank[mapper_id][bus.addr[12:11]]        <= bus.data;
            end
        end
    end

    // 4000->0, 6000->1, 8000->2, A000->3
    assign window    = {bus.addr[15], bus.addr[13]};
    assign bank_sel  = bank[mapper_id][window];
    assign sram_en   = sram_enable[mapper_id][window];
    assign rom_addr  = {bank_sel, bus.addr[12:0]};
    assign rom_valid = ({4'b0000, rom_addr} < rom_size);

    assign sram_cs = cs & sram_en & (bus.rd | (bus.wr & bus.addr[15]));
    assign ram_cs  = cs & ~sram_en & rom_valid & bus.rd;
    assign mem_rnw = ~(sram_cs & bus.wr);

    always_comb begin
        mem_addr = '1;
        if (cs) begin
            if (sram_en) begin
                mem_addr.sram.pad    = '0;
                mem_addr.sram.offset = (sram_size > 16'd2) ? bus.addr[12:0] :
                                       {2'b00, bus.addr[10:0]};
            end else begin
                // 8 KB banks, low bank bit lands in the 14-bit offset
                mem_addr.rom.pad    = '0;
                mem_addr.rom.bank   = {1'b0, bank_sel[7:1]};
                mem_addr.rom.offset = {bank_sel[0], bus.addr[12:0]};
            end
        end
    end

    // Split bank placement must still land inside the ROM image
    a_rom_in_range: assert property (@(posedge clk) disable iff (reset)
        ram_cs |-> (mem_addr < {2'b00, rom_size}));

endmodule

`default_nettype wire

/* verilog/cart_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

// CPU memory bus as seen by the cartridge slot
interface cart_bus_if ();

    logic        mreq;
    logic        rd;
    logic        wr;
    logic [7:0]  data;
    logic [15:0] addr;

    // Driven from the top level ports
    modport slot (
        output mreq, rd, wr, data, addr
    );

    // Mappers only observe the bus
    modport mapper (
        input mreq, rd, wr, data, addr
    );

endinterface

`default_nettype wire

/* verilog/cart_mem_req.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cart_settings.svh"

module cart_mem_req import cart_pkg::*; (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     hit,
    input  wire                     is_sram,
    input  wire                     rd,
    input  wire                     wr,
    input  wire  [7:0]              wdata,
    input  cart_mem_addr_t          addr,
    input  wire                     rnw,
    input  wire                     mem_credit_return,
    output logic                    cpu_wait,
    output logic                    mem_req_valid,
    output logic [`CART_ADDR_W-1:0] mem_req_addr,
    output logic                    mem_req_rnw,
    output logic                    mem_req_sram,
    output logic [7:0]              mem_req_wdata
);

    logic                     active;
    logic                     active_q;
    logic                     start;
    logic                     pending;
    logic [`CART_CREDIT_W-1:0] credits;
    logic [`CART_CREDIT_W:0]   credit_next;
    logic                     can_issue;

    assign active = hit & (rd | wr);
    assign start  = active & ~active_q;

    // Credit is spent in the cycle the request is on the bus
    assign credit_next = {1'b0, credits}
                       + {{`CART_CREDIT_W{1'b0}}, mem_credit_return}
                       - {{`CART_CREDIT_W{1'b0}}, mem_req_valid};
    assign can_issue   = (credit_next != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            credits       <= `CART_CREDIT_W'(`CART_MEM_CREDITS);
            active_q      <= 1'b0;
            pending       <= 1'b0;
            mem_req_valid <= 1'b0;
        end else begin
            credits       <= credit_next[`CART_CREDIT_W-1:0];
            active_q      <= active;
            mem_req_valid <= 1'b0;
            if (pending) begin
                if (can_issue) begin
                    pending       <= 1'b0;
                    mem_req_valid <= 1'b1;
                end
            end else if (start) begin
                if (can_issue) begin
                    mem_req_valid <= 1'b1;
                end else begin
                    pending <= 1'b1;
                end
            end
        end
    end

    // Request fields are frozen at access start
    always_ff @(posedge clk) begin
        if (start && !pending) begin
            mem_req_addr  <= addr;
            mem_req_rnw   <= rnw;
            mem_req_sram  <= is_sram;
            mem_req_wdata <= wdata;
        end
    end

    assign cpu_wait = pending;

    a_credit_max: assert property (@(posedge clk) disable iff (reset)
        credits <= `CART_MEM_CREDITS);

    a_no_req_without_credit: assert property (@(posedge clk) disable iff (reset)
        !(mem_req_valid && credits == '0));

endmodule

`default_nettype wire

/* verilog/cart_pkg.sv */
`default_nettype none

package cart_pkg;

    // Cartridge mapper kinds
    typedef enum logic [2:0] {
        MAPPER_NONE,
        MAPPER_ASCII8,
        MAPPER_ASCII16,
        MAPPER_RTYPE
    } mapper_typ_t;

    // One external memory address, seen as ROM bank/offset or SRAM offset
    typedef union packed {
        struct packed {
            logic [4:0]  pad;
            logic [7:0]  bank;
            logic [13:0] offset;
        } rom;
        struct packed {
            logic [13:0] pad;
            logic [12:0] offset;
        } sram;
    } cart_mem_addr_t;

endpackage

`default_nettype wire

/* verilog/cart_settings.svh */
`ifndef CART_SETTINGS_SVH
`define CART_SETTINGS_SVH

// Outstanding memory requests allowed, also the credit reset value
`define CART_MEM_CREDITS 2

// Credit counter width, must hold CART_MEM_CREDITS
`define CART_CREDIT_W 2

// External memory byte address width
`define CART_ADDR_W 27

`endif

/* verilog/cart_slot.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_slot import cart_pkg::*; (
    cart_bus_if.mapper     bus,
    input  wire     [24:0] rom_size,
    input  wire     [15:0] sram_size,
    input  mapper_typ_t    mapper,
    input  wire            mapper_id,
    input  wire            clk,
    input  wire            reset,
    output logic           hit,
    output logic           is_sram,
    output cart_mem_addr_t mem_addr,
    output logic           mem_rnw
);

    cart_mem_addr_t a16_addr;
    cart_mem_addr_t a8_addr;
    logic           a16_rnw;
    logic           a8_rnw;
    logic           a16_ram_cs;
    logic           a16_sram_cs;
    logic           a8_ram_cs;
    logic           a8_sram_cs;

    cart_ascii16 i_ascii16 (
        .clk       (clk),
        .reset     (reset),
        .bus       (bus),
        .rom_size  (rom_size),
        .sram_size (sram_size),
        .mapper    (mapper),
        .mapper_id (mapper_id),
        .mem_addr  (a16_addr),
        .mem_rnw   (a16_rnw),
        .ram_cs    (a16_ram_cs),
        .sram_cs   (a16_sram_cs)
    );

    cart_ascii8 i_ascii8 (
        .clk       (clk),
        .reset     (reset),
        .bus       (bus),
        .rom_size  (rom_size),
        .sram_size (sram_size),
        .mapper    (mapper),
        .mapper_id (mapper_id),
        .mem_addr  (a8_addr),
        .mem_rnw   (a8_rnw),
        .ram_cs    (a8_ram_cs),
        .sram_cs   (a8_sram_cs)
    );

    // Idle mappers keep their selects low, so OR is enough
    assign hit     = a16_ram_cs | a16_sram_cs | a8_ram_cs | a8_sram_cs;
    assign is_sram = a16_sram_cs | a8_sram_cs;

    // New mapper types add a select term here
    assign mem_addr = (mapper == MAPPER_ASCII8) ? a8_addr : a16_addr;
    assign mem_rnw  = (mapper == MAPPER_ASCII8) ? a8_rnw : a16_rnw;

endmodule

`default_nettype wire

/* verilog/cart_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cart_settings.svh"

module cart_top import cart_pkg::*; (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    cpu_mreq,
    input  wire                    cpu_rd,
    input  wire                    cpu_wr,
    input  wire [7:0]              cpu_data,
    input  wire [15:0]             cpu_addr,
    input  wire [24:0]             rom_size,
    input  wire [15:0]             sram_size,
    input  mapper_typ_t            mapper,
    input  wire                    mapper_id,
    input  wire                    mem_credit_return,
    output wire                    cpu_wait,
    output wire                    mem_req_valid,
    output wire [`CART_ADDR_W-1:0] mem_req_addr,
    output wire                    mem_req_rnw,
    output wire                    mem_req_sram,
    output wire [7:0]              mem_req_wdata
);

    cart_mem_addr_t mem_addr;
    wire            hit;
    wire            is_sram;
    wire            mem_rnw;

    cart_bus_if bus ();

    assign bus.mreq = cpu_mreq;
    assign bus.rd   = cpu_rd;
    assign bus.wr   = cpu_wr;
    assign bus.data = cpu_data;
    assign bus.addr = cpu_addr;

    cart_slot i_slot (
        .bus       (bus.mapper),
        .rom_size  (rom_size),
        .sram_size (sram_size),
        .mapper    (mapper),
        .mapper_id (mapper_id),
        .clk       (clk),
        .reset     (reset),
        .hit       (hit),
        .is_sram   (is_sram),
        .mem_addr  (mem_addr),
        .mem_rnw   (mem_rnw)
    );

    cart_mem_req i_mem_req (
        .clk               (clk),
        .reset             (reset),
        .hit               (hit),
        .is_sram           (is_sram),
        .rd                (bus.rd),
        .wr                (bus.wr),
        .wdata             (bus.data),
        .addr              (mem_addr),
        .rnw               (mem_rnw),
        .mem_credit_return (mem_credit_return),
        .cpu_wait          (cpu_wait),
        .mem_req_valid     (mem_req_valid),
        .mem_req_addr      (mem_req_addr),
        .mem_req_rnw       (mem_req_rnw),
        .mem_req_sram      (mem_req_sram),
        .mem_req_wdata     (mem_req_wdata)
    );

endmodule

`default_nettype wire
